// ==== Bender.yml ====
package:
  name: grid_store

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - grid_pkg.sv
      - row_ram.sv
      - bank_row_cache.sv
      - bank_router.sv
      - grid_config_regs.sv
      - grid_store_top.sv
  - target: test
    files:
      - grid_store_tb.sv

// ==== bank_router.sv ====
`timescale 1ns/100ps
`include "grid_macros.svh"

// data port front end, one request in flight.
module bank_router import grid_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     req,
    input  grid_request_t            request,
    output logic                     ack,
    output tx_data_t                 read_data,
    input  col_limit_t               col_limit,
    output logic                     router_idle,
    output logic [`MACH_N-1:0]       bank_read_en,
    output logic [`MACH_N-1:0]       bank_write_en,
    output bank_addr_t               bank_row,
    output col_addr_t                bank_col,
    output tx_data_t                 bank_data,
    input  logic [`MACH_N-1:0]       bank_ack,
    input  tx_data_t [`MACH_N-1:0]   bank_rdata
);

    typedef enum logic [1:0] {IDLE, ISSUE, DONE} router_state_t;

    router_state_t state, next_state;

    grid_request_t              req_q;
    logic [`BANK_SEL_WIDTH-1:0] bank_sel;
    logic [`MACH_N-1:0]         bank_onehot;
    logic                       sel_ack;
    tx_data_t                   window_mask;

    assign bank_sel  = req_q.row[`BANK_SEL_WIDTH-1:0];
    assign bank_row  = req_q.row[`ROW_WIDTH-1 -: `BANK_ADDR_WIDTH];
    assign bank_col  = req_q.col;
    assign bank_data = req_q.data;
    assign sel_ack   = bank_ack[bank_sel];

    always_comb begin
        for (int b = 0; b < `MACH_N; b++) begin
            bank_onehot[b] = (bank_sel == b);
        end
    end

    // enable held from ISSUE entry through the ack cycle.
    assign bank_read_en  = (state == ISSUE && !req_q.write) ? bank_onehot : '0;
    assign bank_write_en = (state == ISSUE &&  req_q.write) ? bank_onehot : '0;

    // window bit k is column chunk*8+k-1, kept while below the limit.
    always_comb begin
        for (int k = 0; k < `TX_DATA_WIDTH; k++) begin
            window_mask[k] = (`VEC_OFFSET(req_q.col) + k) <= col_limit;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (req) next_state = ISSUE;
            ISSUE:   if (sel_ack) next_state = DONE;
            DONE:    if (!req) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        if (state == IDLE && req) begin
            req_q <= request;
        end
        if (state == ISSUE && sel_ack) begin
            read_data <= bank_rdata[bank_sel] & window_mask;
        end
    end

    assign ack         = (state == DONE);
    assign router_idle = (state == IDLE);

    // client side of the handshake.
    assert property (@(posedge clock) disable iff (reset)
        (req && !ack) |=> (!req || $stable(request)));

endmodule

// ==== bank_row_cache.sv ====
`timescale 1ns/100ps
`include "grid_macros.svh"

// one bank: row RAM plus a one-row working buffer.
// every write goes back to the RAM, so the RAM is never stale.
module bank_row_cache import grid_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       flush,
    input  logic       write_en,
    input  logic       read_en,
    input  bank_addr_t row_addr_in,
    input  col_addr_t  col_addr_in,
    input  tx_data_t   partial_vec_in,
    output logic       ack,
    output logic       busy,
    output tx_data_t   partial_vec_out
);

    typedef enum logic [1:0] {IDLE, FETCH_SAVE, WRITEBACK} bank_state_t;

    bank_state_t state, next_state;

    logic [`BANK_DEPTH-1:0] dirty_list;   // rows that hold real data in the RAM.
    logic       buf_valid;
    bank_addr_t buf_addr;
    row_vec_t   buf_vec;
    row_vec_t   ram_rdata;
    row_vec_t   fetched_vec;
    row_vec_t   view_vec;
    logic       hit;
    logic       fetch_en;
    logic       writeback;
    logic       write_hit;

    assign hit       = buf_valid && (row_addr_in == buf_addr);
    assign fetch_en  = (state == IDLE) && (read_en || write_en) && !hit;
    assign writeback = (state == WRITEBACK);
    assign write_hit = (state == IDLE) && hit && write_en;

    row_ram row_ram_i (
        .clock      (clock),
        .addr       (row_addr_in),
        .write_data (buf_vec),
        .bank_en    (fetch_en || writeback),
        .write_en   (writeback),
        .read_data  (ram_rdata)
    );

    // rows never written read as zero.
    assign fetched_vec = dirty_list[row_addr_in] ? ram_rdata : '0;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (fetch_en) begin
                    next_state = FETCH_SAVE;
                end else if (write_hit) begin
                    next_state = WRITEBACK;
                end
            end
            FETCH_SAVE: next_state = write_en ? WRITEBACK : IDLE;
            WRITEBACK:  next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= IDLE;
            buf_valid  <= 1'b0;
            dirty_list <= '0;
        end else begin
            state <= next_state;
            if (flush) begin
                buf_valid  <= 1'b0;
                dirty_list <= '0;
            end else if (state == FETCH_SAVE) begin
                buf_valid <= 1'b1;
                if (write_en) begin
                    dirty_list[row_addr_in] <= 1'b1;
                end
            end else if (write_hit) begin
                dirty_list[row_addr_in] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == FETCH_SAVE) begin
            buf_addr <= row_addr_in;
            buf_vec  <= fetched_vec;
            if (write_en) begin
                buf_vec[`VEC_OFFSET(col_addr_in) + 1 +: `TX_DATA_WIDTH] <= partial_vec_in;
            end
        end else if (write_hit) begin
            buf_vec[`VEC_OFFSET(col_addr_in) + 1 +: `TX_DATA_WIDTH] <= partial_vec_in;
        end
    end

    // a read miss is answered from the RAM output while the buffer loads.
    assign view_vec        = (state == FETCH_SAVE) ? fetched_vec : buf_vec;
    assign partial_vec_out = view_vec[`VEC_OFFSET(col_addr_in) +: `TX_DATA_WIDTH];

    assign ack  = writeback || (read_en && ((state == IDLE && hit) || state == FETCH_SAVE));
    assign busy = read_en || write_en || writeback;

    assert property (@(posedge clock) disable iff (reset) !(read_en && write_en));

    // the RAM read was issued with last cycle's address.
    assert property (@(posedge clock) disable iff (reset)
        (state == FETCH_SAVE) |-> $stable(row_addr_in));

endmodule

// ==== grid_config_regs.sv ====
`timescale 1ns/100ps
`include "grid_macros.svh"

// configuration port: column limit and clear.
module grid_config_regs import grid_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         cfg_req,
    input  cfg_command_t cfg_command,
    output logic         cfg_ack,
    output col_limit_t   col_limit,
    output logic         flush,
    input  logic         router_idle
);

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT_IDLE, ST_ACK} cfg_state_t;

    cfg_state_t state, next_state;
    col_limit_t limit_sat;

    assign limit_sat = (cfg_command.limit > col_limit_t'(`GRID_W)) ?
                       col_limit_t'(`GRID_W) : cfg_command.limit;

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (cfg_req) begin
                    if (cfg_command.op == CFG_CLEAR) begin
                        next_state = ST_WAIT_IDLE;
                    end else begin
                        next_state = ST_ACK;
                    end
                end
            end
            ST_WAIT_IDLE: if (router_idle) next_state = ST_ACK;  // flush goes out here.
            ST_ACK:       if (!cfg_req) next_state = ST_IDLE;
            default:      next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= ST_IDLE;
            col_limit <= col_limit_t'(`GRID_W);
        end else begin
            state <= next_state;
            if (state == ST_IDLE && cfg_req && cfg_command.op == CFG_SET_LIMIT) begin
                col_limit <= limit_sat;
            end
        end
    end

    assign flush   = (state == ST_WAIT_IDLE) && router_idle;  // single cycle.
    assign cfg_ack = (state == ST_ACK);

endmodule

// ==== grid_macros.svh ====
`ifndef GRID_MACROS_SVH
`define GRID_MACROS_SVH

// banking of the grid rows.
`define MACH_N            4
`define BANK_SEL_WIDTH    2
`define BANK_DEPTH        16
`define BANK_ADDR_WIDTH   4

// grid geometry.
`define GRID_W            64
`define GRID_VEC_ALIGN_N  72    // column j sits at bit j+1, bit 0 is the zero guard.
`define ROW_WIDTH         6

// client transfer unit.
`define TX_DATA_WIDTH     8
`define COL_ADDR_WIDTH    3

// chunk index to first bit of the chunk.
`define VEC_OFFSET(idx) ((idx) * `TX_DATA_WIDTH)

`endif

// ==== grid_pkg.sv ====
`include "grid_macros.svh"

package grid_pkg;

    typedef logic [`TX_DATA_WIDTH-1:0]     tx_data_t;
    typedef logic [`GRID_VEC_ALIGN_N-1:0]  row_vec_t;
    typedef logic [`BANK_ADDR_WIDTH-1:0]   bank_addr_t;
    typedef logic [`COL_ADDR_WIDTH-1:0]    col_addr_t;

    // low bits pick the bank, high bits the row inside it.
    typedef logic [`ROW_WIDTH-1:0]         grid_row_t;

    // must hold 0 up to and including GRID_W.
    typedef logic [$clog2(`GRID_W+1)-1:0]  col_limit_t;

    typedef struct packed {
        logic      write;
        grid_row_t row;
        col_addr_t col;
        tx_data_t  data;   // ignored on reads.
    } grid_request_t;

    typedef enum logic {
        CFG_SET_LIMIT = 1'b0,
        CFG_CLEAR     = 1'b1
    } cfg_op_t;

    typedef struct packed {
        cfg_op_t    op;
        col_limit_t limit;  // only used by set-limit.
    } cfg_command_t;

endpackage

// ==== grid_store_tb.sv ====
`timescale 1ns/100ps
`include "grid_macros.svh"

module grid_store_tb import grid_pkg::*; ();

    localparam int NUM_TXN     = 412;          // all data and config exchanges below.
    localparam int CYCLE_LIMIT = 20 * NUM_TXN;
    localparam int ACK_WAIT    = 20;

    logic          clock;
    logic          reset;
    logic          req;
    grid_request_t request;
    logic          ack;
    tx_data_t      read_data;
    logic          cfg_req;
    cfg_command_t  cfg_command;
    logic          cfg_ack;
    logic          busy;

    logic [31:0]        rng_state;
    int                 cycle_count;
    logic [`GRID_W-1:0] grid_model [`GRID_W];
    int                 model_limit;
    grid_row_t          last_row;

    grid_store_top grid_store_top_i (
        .clock       (clock),
        .reset       (reset),
        .req         (req),
        .request     (request),
        .ack         (ack),
        .read_data   (read_data),
        .cfg_req     (cfg_req),
        .cfg_command (cfg_command),
        .cfg_ack     (cfg_ack),
        .busy        (busy)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run("run exceeded its cycle budget without finishing the tests");
        end
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL at %0t: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // bit k shows column col*8+k-1, zero left of the grid and at or past the limit.
    function automatic tx_data_t expected_window(input grid_row_t row, input col_addr_t col);
        tx_data_t w;
        int       c;
        for (int k = 0; k < `TX_DATA_WIDTH; k++) begin
            c    = int'(col) * `TX_DATA_WIDTH + k - 1;
            w[k] = (c >= 0 && c < model_limit) ? grid_model[row][c] : 1'b0;
        end
        return w;
    endfunction

    task automatic data_exchange(input logic is_write, input grid_row_t row,
                                 input col_addr_t col, input tx_data_t data,
                                 output tx_data_t rdata);
        int   waited;
        int   hold;
        logic saw_busy;
        @(negedge clock);
        request.write = is_write;
        request.row   = row;
        request.col   = col;
        request.data  = data;
        req           = 1'b1;
        waited        = 0;
        saw_busy      = 1'b0;
        while (ack !== 1'b1 && waited < ACK_WAIT) begin
            @(negedge clock);
            waited++;
            if (busy === 1'b1) begin
                saw_busy = 1'b1;
            end
        end
        if (ack !== 1'b1) begin
            abort_run("data port gave no ack within 20 cycles of req");
        end
        check_value("busy", 1, saw_busy);  // a bank works on every request.
        rdata = read_data;
        hold  = next_random() % 3;
        repeat (hold) begin
            @(negedge clock);
            check_value("ack", 1, ack);  // must wait for req to fall.
        end
        check_value("busy", 0, busy);
        req = 1'b0;
        @(negedge clock);
        if (ack !== 1'b0) begin
            @(negedge clock);
        end
        check_value("ack", 0, ack);
    endtask

    task automatic config_exchange(input cfg_op_t op, input col_limit_t limit);
        int waited;
        int hold;
        @(negedge clock);
        cfg_command.op    = op;
        cfg_command.limit = limit;
        cfg_req           = 1'b1;
        waited            = 0;
        while (cfg_ack !== 1'b1 && waited < ACK_WAIT) begin
            @(negedge clock);
            waited++;
        end
        if (cfg_ack !== 1'b1) begin
            abort_run("configuration port gave no ack within 20 cycles of cfg_req");
        end
        hold = next_random() % 3;
        repeat (hold) begin
            @(negedge clock);
            check_value("cfg_ack", 1, cfg_ack);
        end
        cfg_req = 1'b0;
        @(negedge clock);
        if (cfg_ack !== 1'b0) begin
            @(negedge clock);
        end
        check_value("cfg_ack", 0, cfg_ack);
    endtask

    task automatic write_chunk(input grid_row_t row, input col_addr_t col, input tx_data_t data);
        tx_data_t unused;
        data_exchange(1'b1, row, col, data, unused);
        grid_model[row][int'(col) * `TX_DATA_WIDTH +: `TX_DATA_WIDTH] = data;
    endtask

    task automatic read_and_check(input grid_row_t row, input col_addr_t col);
        tx_data_t got;
        data_exchange(1'b0, row, col, '0, got);
        check_value($sformatf("read_data row %0d chunk %0d", row, col),
                    expected_window(row, col), got);
    endtask

    // reuses the last row now and then, so buffer hits come up too.
    function automatic grid_row_t pick_row();
        logic [31:0] r;
        r = next_random();
        if (r[8:7] == 2'b00) begin
            return last_row;
        end
        last_row = r[`ROW_WIDTH-1:0];
        return last_row;
    endfunction

    task automatic random_ops(input int count);
        logic [31:0] r;
        grid_row_t   row;
        for (int i = 0; i < count; i++) begin
            r   = next_random();
            row = pick_row();
            if (r[0]) begin
                write_chunk(row, r[3:1], r[15:8]);
            end else begin
                read_and_check(row, r[3:1]);
            end
        end
    endtask

    task automatic random_reads(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = next_random();
            read_and_check(r[`ROW_WIDTH-1:0], r[10:8]);
        end
    endtask

    initial begin
        grid_row_t   row;
        logic [31:0] r;
        clock       = 1'b0;
        reset       = 1'b1;
        req         = 1'b0;
        request     = '0;
        cfg_req     = 1'b0;
        cfg_command = '0;
        rng_state   = 32'h36a3d381;
        cycle_count = 0;
        model_limit = `GRID_W;
        last_row    = '0;
        for (int i = 0; i < `GRID_W; i++) begin
            grid_model[i] = '0;
        end
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        random_reads(32);  // nothing written yet.
        random_ops(160);

        // chunks of one row merge without touching their neighbours.
        row = grid_row_t'(next_random());
        for (int c = 0; c < 8; c++) begin
            write_chunk(row, col_addr_t'(c), tx_data_t'(next_random()));
        end
        for (int c = 0; c < 8; c++) begin
            read_and_check(row, col_addr_t'(c));
        end
        write_chunk(row, col_addr_t'(3), tx_data_t'(next_random()));
        for (int c = 0; c < 8; c++) begin
            read_and_check(row, col_addr_t'(c));
        end

        r = next_random();
        config_exchange(CFG_SET_LIMIT, r[6:0]);
        model_limit = (r[6:0] > `GRID_W) ? `GRID_W : int'(r[6:0]);
        random_reads(48);
        config_exchange(CFG_SET_LIMIT, col_limit_t'(`GRID_W));
        model_limit = `GRID_W;
        random_reads(48);

        config_exchange(CFG_CLEAR, '0);
        for (int i = 0; i < `GRID_W; i++) begin
            grid_model[i] = '0;
        end
        random_reads(32);
        random_ops(64);

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== grid_store_top.sv ====
`timescale 1ns/100ps
`include "grid_macros.svh"

module grid_store_top import grid_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  logic          req,
    input  grid_request_t request,
    output logic          ack,
    output tx_data_t      read_data,
    input  logic          cfg_req,
    input  cfg_command_t  cfg_command,
    output logic          cfg_ack,
    output logic          busy
);

    col_limit_t                 col_limit;
    logic                       flush;
    logic                       router_idle;
    logic [`MACH_N-1:0]         bank_read_en;
    logic [`MACH_N-1:0]         bank_write_en;
    bank_addr_t                 bank_row;
    col_addr_t                  bank_col;
    tx_data_t                   bank_data;
    logic [`MACH_N-1:0]         bank_ack;
    logic [`MACH_N-1:0]         bank_busy;
    tx_data_t [`MACH_N-1:0]     bank_rdata;

    grid_config_regs grid_config_regs_i (
        .clock       (clock),
        .reset       (reset),
        .cfg_req     (cfg_req),
        .cfg_command (cfg_command),
        .cfg_ack     (cfg_ack),
        .col_limit   (col_limit),
        .flush       (flush),
        .router_idle (router_idle)
    );

    bank_router bank_router_i (
        .clock         (clock),
        .reset         (reset),
        .req           (req),
        .request       (request),
        .ack           (ack),
        .read_data     (read_data),
        .col_limit     (col_limit),
        .router_idle   (router_idle),
        .bank_read_en  (bank_read_en),
        .bank_write_en (bank_write_en),
        .bank_row      (bank_row),
        .bank_col      (bank_col),
        .bank_data     (bank_data),
        .bank_ack      (bank_ack),
        .bank_rdata    (bank_rdata)
    );

    for (genvar b = 0; b < `MACH_N; b++) begin : g_bank
        bank_row_cache bank_row_cache_i (
            .clock           (clock),
            .reset           (reset),
            .flush           (flush),
            .write_en        (bank_write_en[b]),
            .read_en         (bank_read_en[b]),
            .row_addr_in     (bank_row),
            .col_addr_in     (bank_col),
            .partial_vec_in  (bank_data),
            .ack             (bank_ack[b]),
            .busy            (bank_busy[b]),
            .partial_vec_out (bank_rdata[b])
        );
    end

    assign busy = |bank_busy;

endmodule

// ==== row_ram.sv ====
`timescale 1ns/100ps
`include "grid_macros.svh"

// one row per address, read data one cycle after the address.
module row_ram import grid_pkg::*; (
    input  logic       clock,
    input  bank_addr_t addr,
    input  row_vec_t   write_data,
    input  logic       bank_en,
    input  logic       write_en,
    output row_vec_t   read_data
);

    row_vec_t mem [`BANK_DEPTH];

    always_ff @(posedge clock) begin
        if (bank_en) begin
            if (write_en) begin
                mem[addr] <= write_data;
            end else begin
                read_data <= mem[addr];  // holds between fetches.
            end
        end
    end

endmodule

// ==== sources.f ====
+incdir+.
grid_pkg.sv
row_ram.sv
bank_row_cache.sv
bank_router.sv
grid_config_regs.sv
grid_store_top.sv
grid_store_tb.sv
